// ==== verilog/lauPkg.sv ====
// Arithmetic library package: log2floor function and adder speed enum
package lauPkg;

	//////////////////////////////////////////////////
	// Integer helpers
	//////////////////////////////////////////////////

	// Floor of log2, argument must be positive
	// Returns -1 for zero as a guard value
	function automatic int log2floor(input int n);
		int result;
		int pow;
		result = -1;
		pow = 1;
		// Count doublings that stay within n
		while (pow <= n) begin
			result++;
			pow = pow * 2;
		end
		return result;
	endfunction

	//////////////////////////////////////////////////
	// Adder architecture selection
	//////////////////////////////////////////////////

	// SLOW picks a ripple chain
	// MEDIUM and FAST pick a parallel-prefix network
	typedef enum logic [1:0] {
		SLOW   = 2'b00,
		MEDIUM = 2'b01,
		FAST   = 2'b10
	} speed_e;

endpackage

// ==== verilog/addMulPkg.sv ====
// Adder-multiplier configuration package: default widths, speed, row and latency functions
package addMulPkg;

	import lauPkg::*;

	//////////////////////////////////////////////////
	// Defaults for the top level
	//////////////////////////////////////////////////

	// Width of XS and XC
	localparam int widthXDef = 8;
	// Width of Y
	localparam int widthYDef = 8;
	// Final adder style
	localparam speed_e speedDef = FAST;

	//////////////////////////////////////////////////
	// Derived quantities
	//////////////////////////////////////////////////

	// One row per multiplier digit plus the correction row
	function automatic int ppRows(input int widthX);
		return widthX + 1;
	endfunction

	// Feeder cycle, one cycle per CSA row, drain cycle
	function automatic int pipeLatency(input int widthX);
		int csaRows;
		csaRows = widthX - 1;
		return 1 + csaRows + 1;
	endfunction

endpackage

// ==== verilog/addMulPpGenSgn.sv ====
// Combinational signed partial-product generator for the adder-multiplier
`timescale 1ns/1ps

module addMulPpGenSgn #(
	parameter int widthX = 8,
	parameter int widthY = 8,
	localparam int widthP = widthX + widthY
) (
	input  logic [widthX-1:0]              XS,
	input  logic [widthX-1:0]              XC,
	input  logic [widthY-1:0]              Y,
	output logic [(widthX+1)*widthP-1:0]   PP
);

	// Digit masks, digit = M1 + 2*M2
	logic [widthX-1:0] M1;
	logic [widthX-1:0] M2;
	// Y and inverted Y, both with a zero below and sign above
	logic [widthY+1:0] yExt;
	logic [widthY+1:0] yInv;
	// One product row per entry
	logic [widthX:0][widthP-1:0] rows;

	//////////////////////////////////////////////////
	// Digit recoding
	//////////////////////////////////////////////////

	// Bit pair sum of XS and XC is 0, 1 or 2
	assign M1 = XS ^ XC;
	assign M2 = XS & XC;

	// yExt[k+1] selects Y, yExt[k] selects 2Y
	assign yExt = {Y[widthY-1], Y, 1'b0};
	assign yInv = {~Y[widthY-1], ~Y, 1'b0};

	//////////////////////////////////////////////////
	// Row construction
	//////////////////////////////////////////////////

	always_comb begin
		rows = '0;
		// Positive digits, sign extended up to the top bit
		for (int i = 0; i < widthX - 1; i++) begin
			for (int k = 0; k <= widthY; k++) begin
				rows[i][i+k] = (M1[i] & yExt[k+1]) | (M2[i] & yExt[k]);
			end
			for (int k = widthY + 1; k < widthP - i; k++) begin
				rows[i][i+k] = (M1[i] | M2[i]) & yExt[widthY+1];
			end
		end
		// Top digit has negative weight
		// Ones' complement of Y here, the +1 goes into the last row
		for (int k = 0; k <= widthY; k++) begin
			rows[widthX-1][widthX-1+k] =
				(M1[widthX-1] & yInv[k+1]) | (M2[widthX-1] & yInv[k]);
		end
		// Correction bits, +1 for -Y and +2 for -2Y
		rows[widthX][widthX-1] = M1[widthX-1];
		rows[widthX][widthX]   = M2[widthX-1];
	end

	// Row i lands in bits [i*widthP +: widthP]
	assign PP = rows;

endmodule

// ==== verilog/ppStage.sv ====
// Feeder stage: registers the partial-product rows behind a valid/ready handshake
`timescale 1ns/1ps

module ppStage #(
	parameter int widthX = 8,
	parameter int widthY = 8,
	localparam int widthP = widthX + widthY
) (
	input  logic                                        clk,
	input  logic                                        rstN,
	// Upstream side
	input  logic                                        inValid,
	output logic                                        inReady,
	input  logic [widthX-1:0]                           XS,
	input  logic [widthX-1:0]                           XC,
	input  logic [widthY-1:0]                           Y,
	// Downstream side
	output logic                                        outValid,
	input  logic                                        outReady,
	output logic [addMulPkg::ppRows(widthX)*widthP-1:0] PP
);

	import addMulPkg::*;

	// Size of the full row bundle
	localparam int ppBits = ppRows(widthX) * widthP;

	// Generator output, before the stage register
	logic [ppBits-1:0] ppComb;

	addMulPpGenSgn #(
		.widthX (widthX),
		.widthY (widthY)
	) ppGen (
		.XS (XS),
		.XC (XC),
		.Y  (Y),
		.PP (ppComb)
	);

	// Free slot or slot drained this cycle
	assign inReady = !outValid || outReady;

	//////////////////////////////////////////////////
	// Stage register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
			PP       <= '0;
		end else begin
			// Empty slot takes a bubble as well
			if (inReady) begin
				outValid <= inValid;
			end
			if (inValid && inReady) begin
				PP <= ppComb;
			end
		end
	end

endmodule

// ==== verilog/csaRowStage.sv ====
// Carry-save row stage: folds one partial-product row into sum and carry, registered
`timescale 1ns/1ps

module csaRowStage #(
	parameter int widthX = 8,
	parameter int widthY = 8,
	parameter int rowIdx = 0,
	localparam int widthP = widthX + widthY
) (
	input  logic                                        clk,
	input  logic                                        rstN,
	// Upstream side
	input  logic                                        inValid,
	output logic                                        inReady,
	input  logic [widthP-1:0]                           sumIn,
	input  logic [widthP-1:0]                           carryIn,
	input  logic [addMulPkg::ppRows(widthX)*widthP-1:0] rowsIn,
	// Downstream side
	output logic                                        outValid,
	input  logic                                        outReady,
	output logic [widthP-1:0]                           sumOut,
	output logic [widthP-1:0]                           carryOut,
	output logic [addMulPkg::ppRows(widthX)*widthP-1:0] rowsOut
);

	import addMulPkg::*;

	// Rows 0 and 1 seed the chain, so this stage takes row rowIdx+2
	localparam int addIdx = rowIdx + 2;
	localparam int ppBits = ppRows(widthX) * widthP;

	logic [widthP-1:0] addend;
	logic [widthP-1:0] sumNext;
	logic [widthP-1:0] majority;
	logic [widthP-1:0] carryNext;

	//////////////////////////////////////////////////
	// 3:2 compression
	//////////////////////////////////////////////////

	assign addend = rowsIn[addIdx*widthP +: widthP];

	// One full adder per column
	assign sumNext  = sumIn ^ carryIn ^ addend;
	assign majority = (sumIn & carryIn) | (sumIn & addend) | (carryIn & addend);

	// Carry moves one column up, top carry falls off (mod 2^widthP)
	assign carryNext = {majority[widthP-2:0], 1'b0};

	assign inReady = !outValid || outReady;

	//////////////////////////////////////////////////
	// Stage registers
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	// Payload only moves on a transfer
	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			sumOut   <= sumNext;
			carryOut <= carryNext;
			rowsOut  <= rowsIn[ppBits-1:0];
		end
	end

endmodule

// ==== verilog/cpaStage.sv ====
// Drain stage: registered carry-propagate adder, ripple or Sklansky prefix by speed
`timescale 1ns/1ps

module cpaStage #(
	parameter int             widthX = 8,
	parameter int             widthY = 8,
	parameter lauPkg::speed_e speed  = lauPkg::FAST,
	localparam int            widthP = widthX + widthY
) (
	input  logic              clk,
	input  logic              rstN,
	// Upstream side
	input  logic              inValid,
	output logic              inReady,
	input  logic [widthP-1:0] sumIn,
	input  logic [widthP-1:0] carryIn,
	// Downstream side
	output logic              outValid,
	input  logic              outReady,
	output logic [widthP-1:0] P
);

	import lauPkg::*;

	// Adder result before the output register
	logic [widthP-1:0] sumComb;

	generate
		if (speed == SLOW) begin : genRipple

			//////////////////////////////////////////////////
			// Ripple-carry chain
			//////////////////////////////////////////////////

			always_comb begin
				logic c;
				c = 1'b0;
				for (int i = 0; i < widthP; i++) begin
					sumComb[i] = sumIn[i] ^ carryIn[i] ^ c;
					c = (sumIn[i] & carryIn[i]) | (c & (sumIn[i] ^ carryIn[i]));
				end
			end

		end else begin : genPrefix

			//////////////////////////////////////////////////
			// Sklansky parallel prefix
			//////////////////////////////////////////////////

			// Combining levels, the topmost only passes through for powers of two
			localparam int levels = log2floor(widthP) + 1;

			// Level 0 is bitwise, level l spans 2^l columns
			logic [levels:0][widthP-1:0] gen;
			logic [levels:0][widthP-1:0] prop;

			always_comb begin
				int j;
				gen[0]  = sumIn & carryIn;
				prop[0] = sumIn ^ carryIn;
				for (int l = 1; l <= levels; l++) begin
					for (int i = 0; i < widthP; i++) begin
						// Upper half of a block takes the lower half's group
						if (((i >> (l - 1)) & 1) == 1) begin
							j = ((i >> (l - 1)) << (l - 1)) - 1;
							gen[l][i]  = gen[l-1][i] | (prop[l-1][i] & gen[l-1][j]);
							prop[l][i] = prop[l-1][i] & prop[l-1][j];
						end else begin
							gen[l][i]  = gen[l-1][i];
							prop[l][i] = prop[l-1][i];
						end
					end
				end
			end

			// Carry into bit i is the group generate of bits i-1..0
			assign sumComb = prop[0] ^ {gen[levels][widthP-2:0], 1'b0};

		end
	endgenerate

	assign inReady = !outValid || outReady;

	//////////////////////////////////////////////////
	// Output register
	//////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			outValid <= 1'b0;
		end else if (inReady) begin
			outValid <= inValid;
		end
	end

	always_ff @(posedge clk) begin
		if (inValid && inReady) begin
			P <= sumComb;
		end
	end

endmodule

// ==== verilog/addMulPipe.sv ====
// Top level: feeder stage, carry-save row chain and carry-propagate drain
`timescale 1ns/1ps

module addMulPipe #(
	parameter int             widthX = addMulPkg::widthXDef,
	parameter int             widthY = addMulPkg::widthYDef,
	parameter lauPkg::speed_e speed  = addMulPkg::speedDef,
	localparam int            widthP = widthX + widthY
) (
	input  logic              clk,
	input  logic              rstN,
	// Operand side
	input  logic              inValid,
	output logic              inReady,
	input  logic [widthX-1:0] XS,
	input  logic [widthX-1:0] XC,
	input  logic [widthY-1:0] Y,
	// Product side
	output logic              outValid,
	input  logic              outReady,
	output logic [widthP-1:0] P
);

	import addMulPkg::*;

	localparam int rowBits = ppRows(widthX) * widthP;
	// Number of carry-save rows
	localparam int csaCount = widthX - 1;

	// Chain links, index 0 is the feeder output, index csaCount feeds the drain
	logic [csaCount:0]              stValid;
	logic [csaCount:0]              stReady;
	logic [csaCount:0][widthP-1:0]  stSum;
	logic [csaCount:0][widthP-1:0]  stCarry;
	logic [csaCount:0][rowBits-1:0] stRows;

	//////////////////////////////////////////////////
	// Feeder
	//////////////////////////////////////////////////

	ppStage #(
		.widthX (widthX),
		.widthY (widthY)
	) feeder (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.XS       (XS),
		.XC       (XC),
		.Y        (Y),
		.outValid (stValid[0]),
		.outReady (stReady[0]),
		.PP       (stRows[0])
	);

	// First two rows seed the carry-save pair
	assign stSum[0]   = stRows[0][0 +: widthP];
	assign stCarry[0] = stRows[0][widthP +: widthP];

	//////////////////////////////////////////////////
	// Carry-save rows
	//////////////////////////////////////////////////

	// Last link's row bundle is spent, the drain only needs sum and carry
	for (genvar k = 0; k < csaCount; k++) begin : genCsa
		csaRowStage #(
			.widthX (widthX),
			.widthY (widthY),
			.rowIdx (k)
		) csaRow (
			.clk      (clk),
			.rstN     (rstN),
			.inValid  (stValid[k]),
			.inReady  (stReady[k]),
			.sumIn    (stSum[k]),
			.carryIn  (stCarry[k]),
			.rowsIn   (stRows[k]),
			.outValid (stValid[k+1]),
			.outReady (stReady[k+1]),
			.sumOut   (stSum[k+1]),
			.carryOut (stCarry[k+1]),
			.rowsOut  (stRows[k+1])
		);
	end

	//////////////////////////////////////////////////
	// Drain
	//////////////////////////////////////////////////

	cpaStage #(
		.widthX (widthX),
		.widthY (widthY),
		.speed  (speed)
	) drain (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (stValid[csaCount]),
		.inReady  (stReady[csaCount]),
		.sumIn    (stSum[csaCount]),
		.carryIn  (stCarry[csaCount]),
		.outValid (outValid),
		.outReady (outReady),
		.P        (P)
	);

endmodule

// ==== tests/tbUtil.svh ====
// Testbench helpers: Galois LFSR, reference product function, typed compare tasks
`ifndef tbUtilSvh
`define tbUtilSvh

//////////////////////////////////////////////////
// Random source
//////////////////////////////////////////////////

// x^32 + x^22 + x^2 + x + 1 in right-shifting form
localparam logic [31:0] lfsrTaps = 32'h80200003;

// One step, one bit out
function automatic logic lfsrBit();
	logic outBit;
	outBit = lfsrState[0];
	lfsrState = lfsrState >> 1;
	if (outBit) begin
		lfsrState = lfsrState ^ lfsrTaps;
	end
	return outBit;
endfunction

// n bits, one step each, first bit ends up on top
function automatic logic [31:0] randBits(input int n);
	logic [31:0] v;
	v = '0;
	for (int i = 0; i < n; i++) begin
		v = {v[30:0], lfsrBit()};
	end
	return v;
endfunction

//////////////////////////////////////////////////
// Reference model and compares
//////////////////////////////////////////////////

// (XS + XC) * Y in full precision, low widthP bits kept
function automatic logic [widthP-1:0] refProduct(input logic [widthX-1:0] xs,
		input logic [widthX-1:0] xc, input logic [widthY-1:0] y);
	longint a;
	longint b;
	longint c;
	longint prod;
	a = longint'($signed(xs));
	b = longint'($signed(xc));
	c = longint'($signed(y));
	prod = (a + b) * c;
	return prod[widthP-1:0];
endfunction

task automatic checkP(input string name, input logic [widthP-1:0] got,
		input logic [widthP-1:0] exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
		valueErrors++;
	end
endtask

task automatic checkBit(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("ERR %0t %s got %b expected %b", $time, name, got, exp);
		valueErrors++;
	end
endtask

`endif

// ==== tests/addMulPipeTb.sv ====
// Testbench for addMulPipe: clock, reset, directed and random stimulus, scoreboard, timeout
`timescale 1ns/1ps

module addMulPipeTb;

	import addMulPkg::*;

	localparam int widthX = widthXDef;
	localparam int widthY = widthYDef;
	localparam int widthP = widthX + widthY;
	localparam int latency = pipeLatency(widthX);
	localparam int nDirected = 6;
	localparam int nRandom = 300;
	localparam int nPressure = 300;
	// Half-rate output under back-pressure, so two cycles per item
	localparam int cycleLimit = 2 * (nDirected + nRandom + nPressure) + latency + 300;
	// Idle cycles a drain may take before the count check takes over
	localparam int drainLimit = 8 * latency;
	// Sample point after the falling edge
	localparam time sampleDelay = 1;
	localparam logic [widthX-1:0] maxX = {1'b0, {(widthX-1){1'b1}}};
	localparam logic [widthX-1:0] minX = {1'b1, {(widthX-1){1'b0}}};
	localparam logic [widthY-1:0] maxY = {1'b0, {(widthY-1){1'b1}}};
	localparam logic [widthY-1:0] minY = {1'b1, {(widthY-1){1'b0}}};

	logic clk;
	logic rstN;
	logic inValid;
	logic inReady;
	logic [widthX-1:0] XS;
	logic [widthX-1:0] XC;
	logic [widthY-1:0] Y;
	logic outValid;
	logic outReady;
	logic [widthP-1:0] P;

	// Scoreboard state
	logic [widthP-1:0] expQ[$];
	int accepted = 0;
	int received = 0;
	int latencyIdx = -1;
	int acceptCycle = 0;
	int cycles = 0;
	int valueErrors = 0;
	int otherErrors = 0;
	bit pressure = 0;
	logic [31:0] lfsrState;

	`include "tbUtil.svh"

	addMulPipe #(
		.widthX (widthXDef),
		.widthY (widthYDef),
		.speed  (speedDef)
	) DUT (
		.clk      (clk),
		.rstN     (rstN),
		.inValid  (inValid),
		.inReady  (inReady),
		.XS       (XS),
		.XC       (XC),
		.Y        (Y),
		.outValid (outValid),
		.outReady (outReady),
		.P        (P)
	);

	always #5 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= cycleLimit) begin
			$display("Timeout: run went past %0d cycles without finishing", cycleLimit);
			$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors + 1);
			$display("Errors found");
			$finish;
		end
	end

	//////////////////////////////////////////////////
	// Drive tasks
	//////////////////////////////////////////////////

	// Falling edge, outReady random only under back-pressure
	task automatic driveCycle(input logic valid);
		@(negedge clk);
		inValid = valid;
		outReady = pressure ? lfsrBit() : 1'b1;
	endtask

	task automatic idleCycle();
		driveCycle(1'b0);
		#sampleDelay;
	endtask

	// Holds the operands until the DUT takes them
	task automatic sendItem(input logic [widthX-1:0] xs, input logic [widthX-1:0] xc,
			input logic [widthY-1:0] y);
		bit done;
		done = 0;
		while (!done) begin
			driveCycle(1'b1);
			XS = xs;
			XC = xc;
			Y = y;
			#sampleDelay;
			if (inReady) begin
				expQ.push_back(refProduct(xs, xc, y));
				if (accepted == latencyIdx) begin
					acceptCycle = cycles;
				end
				accepted++;
				done = 1;
			end
		end
		// Random gap under back-pressure
		if (pressure && lfsrBit()) begin
			idleCycle();
		end
	endtask

	task automatic randomItem();
		logic [31:0] rx;
		logic [31:0] rc;
		logic [31:0] ry;
		rx = randBits(widthX);
		rc = randBits(widthX);
		ry = randBits(widthY);
		sendItem(rx[widthX-1:0], rc[widthX-1:0], ry[widthY-1:0]);
	endtask

	// Gives up after drainLimit idle cycles
	task automatic waitDrain();
		int waited;
		waited = 0;
		while (received < accepted && waited < drainLimit) begin
			idleCycle();
			waited++;
		end
	endtask

	//////////////////////////////////////////////////
	// Compare process
	//////////////////////////////////////////////////

	initial begin
		@(posedge rstN);
		forever begin
			@(negedge clk);
			#sampleDelay;
			// Input stalls only behind a blocked output
			if (!inReady) begin
				checkBit("outValid", outValid, 1'b1);
				checkBit("outReady", outReady, 1'b0);
			end
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					$display("Result at %0t arrived with no input pending", $time);
					otherErrors++;
				end else begin
					checkP("P", P, expQ.pop_front());
					if (received == latencyIdx && cycles - acceptCycle != latency) begin
						$display("First result took %0d cycles instead of %0d",
							cycles - acceptCycle, latency);
						otherErrors++;
					end
					received++;
				end
			end
		end
	end

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		inValid = 1'b0;
		XS = '0;
		XC = '0;
		Y = '0;
		outReady = 1'b1;
		lfsrState = 32'hfcf0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		rstN = 1'b1;
		// Empty pipeline stays quiet
		repeat (5) begin
			idleCycle();
			checkBit("outValid", outValid, 1'b0);
			checkBit("inReady", inReady, 1'b1);
		end
		// Corner products, min case wraps
		sendItem('0, '0, '0);
		sendItem(maxX, maxX, maxY);
		sendItem(minX, minX, minY);
		sendItem(widthX'(37), widthX'(-37), widthY'(99));
		sendItem(widthX'(100), widthX'(27), minY);
		sendItem(minX, maxX, minY);
		waitDrain();
		// Full-rate stream, first item timed
		latencyIdx = accepted;
		repeat (nRandom) randomItem();
		waitDrain();
		pressure = 1;
		repeat (nPressure) randomItem();
		waitDrain();
		pressure = 0;
		// Extra results would show up here
		repeat (2 * latency) idleCycle();
		if (expQ.size() != 0 || received != accepted) begin
			$display("Drain mismatch: %0d inputs accepted, %0d results received, %0d left",
				accepted, received, expQ.size());
			otherErrors++;
		end
		$display("Value errors: %0d, other errors: %0d", valueErrors, otherErrors);
		if (valueErrors + otherErrors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== addMulPipe.f ====
+incdir+tests
verilog/lauPkg.sv
verilog/addMulPkg.sv
verilog/addMulPpGenSgn.sv
verilog/ppStage.sv
verilog/csaRowStage.sv
verilog/cpaStage.sv
verilog/addMulPipe.sv
tests/addMulPipeTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the addMulPipe testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal -j 0 --top-module addMulPipeTb -f addMulPipe.f \
	|| { echo "Build failed"; exit 1; }
./obj_dir/VaddMulPipeTb | tee /dev/stderr | grep -q "^No errors$" \
	&& { echo "PASS"; exit 0; } \
	|| { echo "FAIL"; exit 1; }
